// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpuControllerTb -f sources.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    && ! grep -q "Test failed" sim.log \
    && echo "Simulation passed" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }

// ==== source/cpuController.sv ====
module cpuController (
    input  logic clk,
    input  logic rst,
    input  cpuCtrlPkg::instrWord opcode,
    input  logic [cpuCtrlPkg::flagWidth-1:0] flags,
    input  logic stall,
    input  logic irq,
    output logic [cpuCtrlPkg::memSelWidth-1:0] memAddr,
    output logic enPC,
    output logic saveOpcode,
    output logic saveMem1,
    output logic enFP,
    output logic [cpuCtrlPkg::aluFuncWidth-1:0] aluFunc,
    output logic [cpuCtrlPkg::aluSelWidth-1:0] aluA,
    output logic [cpuCtrlPkg::aluSelWidth-1:0] aluB,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic we,
    output logic re,
    output logic [cpuCtrlPkg::writeSelWidth-1:0] writeDataSource,
    output logic enF,
    output logic [cpuCtrlPkg::flagSelWidth-1:0] sourceF,
    output logic enSP,
    output logic turnOffIRQ,
    output logic readStack,
    output logic isMul,
    output logic initSPFP,
    output cpuCtrlPkg::ctrlState state // Debug view
);
    import cpuCtrlPkg::*;

    ctrlState mainState; // Where FETCH goes next
    logic isValid;
    logic stepRun;
    logic [stepWidth-1:0] step;
    logic stepLast;

    instrDecoder decoder0 (
        .opcode(opcode),
        .flags(flags),
        .mainState(mainState),
        .isValid(isValid)
    );

    ctrlSequencer sequencer0 (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .irq(irq),
        .mainState(mainState),
        .isValid(isValid),
        .stepLast(stepLast),
        .state(state),
        .stepRun(stepRun)
    );

    stackStepCounter stepCounter0 (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .stepRun(stepRun),
        .step(step),
        .stepLast(stepLast)
    );

    microOpDecoder microOp0 (
        .state(state),
        .step(step),
        .opcode(opcode),
        .memAddr(memAddr),
        .enPC(enPC),
        .saveOpcode(saveOpcode),
        .saveMem1(saveMem1),
        .enFP(enFP),
        .aluFunc(aluFunc),
        .aluA(aluA),
        .aluB(aluB),
        .enA(enA),
        .enB(enB),
        .enC(enC),
        .we(we),
        .re(re),
        .writeDataSource(writeDataSource),
        .enF(enF),
        .sourceF(sourceF),
        .enSP(enSP),
        .turnOffIRQ(turnOffIRQ),
        .readStack(readStack),
        .isMul(isMul),
        .initSPFP(initSPFP)
    );

endmodule

// ==== source/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    localparam int opWidth = 16; // Instruction word
    localparam int flagWidth = 4;
    localparam int aluFuncWidth = 4;
    localparam int destWidth = 3;
    localparam int memSelWidth = 3;
    localparam int aluSelWidth = 4;
    localparam int writeSelWidth = 4;
    localparam int flagSelWidth = 2;
    localparam int intSaveSteps = 8; // Words pushed on interrupt entry
    localparam int stepWidth = 3;

    localparam logic [aluFuncWidth-1:0] ALU_ADD = 4'd0;
    localparam logic [aluFuncWidth-1:0] ALU_SUB = 4'd2;
    localparam logic [aluFuncWidth-1:0] ALU_MUL = 4'd4;

    localparam logic [destWidth-1:0] DEST_0 = 3'd0; // SP or flags, depending on class
    localparam logic [destWidth-1:0] DEST_A = 3'd1;
    localparam logic [destWidth-1:0] DEST_B = 3'd2;
    localparam logic [destWidth-1:0] DEST_C = 3'd3;
    localparam logic [destWidth-1:0] DEST_ADR = 3'd4; // Memory at A

    localparam logic [memSelWidth-1:0] MEM_FROM_PC = 3'd0;
    localparam logic [memSelWidth-1:0] MEM_FROM_A = 3'd1;
    localparam logic [memSelWidth-1:0] MEM_FROM_SP = 3'd2;
    localparam logic [memSelWidth-1:0] MEM_FROM_ALU = 3'd3;

    // Codes 0 to 3 pick a register directly
    localparam logic [aluSelWidth-1:0] ALU1_FROM_PC = 4'd4;
    localparam logic [aluSelWidth-1:0] ALU1_FROM_SP = 4'd5;
    localparam logic [aluSelWidth-1:0] ALU1_FROM_MEM = 4'd6;
    localparam logic [aluSelWidth-1:0] ALU1_FROM_INTADDR = 4'd7; // Interrupt vector

    localparam logic [aluSelWidth-1:0] ALU2_FROM_0 = 4'd4;
    localparam logic [aluSelWidth-1:0] ALU2_FROM_2 = 4'd5;
    localparam logic [aluSelWidth-1:0] ALU2_FROM_OP = 4'd6;
    localparam logic [aluSelWidth-1:0] ALU2_FROM_ADDR = 4'd7;
    localparam logic [aluSelWidth-1:0] ALU2_FROM_FADDR = 4'd8;

    localparam logic [writeSelWidth-1:0] WRITE_FROM_ALU = 4'd0;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_PC2 = 4'd1;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_PC1 = 4'd2;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_FP = 4'd3;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_F = 4'd4;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_INTDATA = 4'd5;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_C = 4'd6;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_B = 4'd7;
    localparam logic [writeSelWidth-1:0] WRITE_FROM_A = 4'd8;

    localparam logic [flagSelWidth-1:0] FLAG_FROM_ALU = 2'd0;
    localparam logic [flagSelWidth-1:0] FLAG_FROM_ALU_OUT = 2'd1;

    typedef enum logic [3:0] {
        START = 4'd0,
        FETCH = 4'd1,
        ATYPE = 4'd2,
        ITYPE = 4'd3,
        SITYPE = 4'd4,
        JMP = 4'd5,
        FTYPE = 4'd6,
        PUSH1 = 4'd7,
        PUSH2 = 4'd8,
        POP1 = 4'd9,
        POP2 = 4'd10,
        INTSAVE = 4'd11,
        INTVECTOR = 4'd12,
        HALT = 4'hf // CPU stopped until reset
    } ctrlState;

    typedef struct packed {
        logic [3:0] cls;
        logic [2:0] src1;
        logic [3:0] func;
        logic [1:0] aluB;
        logic [destWidth-1:0] dest;
    } aTypeFmt;

    typedef struct packed {
        logic [3:0] cls; // Low two bits give the ALU function
        logic [2:0] src1; // Also the destination
        logic signExt;
        logic [7:0] operand;
    } iTypeFmt;

    typedef struct packed {
        logic [3:0] cls;
        logic [2:0] src1;
        logic [1:0] shiftFunc;
        logic [destWidth-1:0] dest;
        logic [3:0] amount;
    } siTypeFmt;

    typedef struct packed {
        logic [3:0] cls;
        logic polarity; // Branch when flag equals this
        logic [1:0] flagSel;
        logic loadStore;
        logic [7:0] offset;
    } branchFmt;

    typedef union packed {
        logic [opWidth-1:0] raw;
        aTypeFmt aType;
        iTypeFmt iType;
        siTypeFmt siType;
        branchFmt branch;
    } instrWord;

endpackage

// ==== source/ctrlSequencer.sv ====
module ctrlSequencer (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic irq,
    input  cpuCtrlPkg::ctrlState mainState,
    input  logic isValid,
    input  logic stepLast,
    output cpuCtrlPkg::ctrlState state,
    output logic stepRun
);
    import cpuCtrlPkg::*;

    ctrlState nextState;

    always_ff @(posedge clk) begin
        if (rst)
            state <= START;
        else if (!stall) // Whole sequence freezes on stall
            state <= nextState;
    end

    always_comb begin
        nextState = HALT;
        case (state)
            START: nextState = FETCH;
            FETCH: nextState = isValid ? mainState : HALT;
            ATYPE, ITYPE, SITYPE: nextState = FETCH;
            JMP, FTYPE: nextState = FETCH;
            PUSH1: nextState = PUSH2;
            PUSH2: nextState = FETCH;
            POP1: nextState = POP2;
            POP2: nextState = FETCH;
            INTSAVE: nextState = stepLast ? INTVECTOR : INTSAVE;
            INTVECTOR: nextState = FETCH;
            HALT: nextState = HALT;
            default: nextState = HALT;
        endcase
        // Interrupt takes the slot of the next fetch
        if (nextState == FETCH && irq)
            nextState = INTSAVE;
    end

    assign stepRun = (state == INTSAVE);

    haltSticky: assert property (@(posedge clk)
        (state == HALT && !rst) |=> (state == HALT))
        else $error("HALT left without reset");

    // Eight save steps come from the step counter
    saveFrameLength: assert property (@(posedge clk) disable iff (rst)
        (state == INTSAVE && !stepLast) |=> (state == INTSAVE))
        else $error("INTSAVE left before the last save step");

endmodule

// ==== source/instrDecoder.sv ====
module instrDecoder (
    input  cpuCtrlPkg::instrWord opcode,
    input  logic [cpuCtrlPkg::flagWidth-1:0] flags,
    output cpuCtrlPkg::ctrlState mainState,
    output logic isValid
);
    import cpuCtrlPkg::*;

    logic [3:0] cls;
    logic memSource; // Source field points at memory
    logic badDestA;
    logic badDestI;
    logic badDestSi;

    assign cls = opcode.raw[15:12];
    assign memSource = opcode.aType.src1[2];
    assign badDestA = opcode.aType.dest > DEST_ADR;
    assign badDestI = opcode.iType.src1 > DEST_ADR;
    assign badDestSi = opcode.siType.dest > DEST_ADR;

    always_comb begin
        mainState = HALT; // Unknown class stops the CPU
        isValid = 1'b0;
        if (cls == 4'b0000) begin // A type
            mainState = ATYPE;
            isValid = !memSource && !badDestA;
        end else if (cls == 4'b1000) begin
            mainState = HALT; // Byte move not supported
        end else if (cls[3:2] == 2'b01) begin // I type
            mainState = ITYPE;
            isValid = !badDestI;
        end else if (cls[3:2] == 2'b11) begin // Relative jump
            mainState = JMP;
            isValid = 1'b1;
        end else if (cls == 4'b1001) begin
            mainState = HALT; // Register jump not supported
        end else if (cls == 4'b0001) begin // SI type
            mainState = SITYPE;
            isValid = !memSource && !badDestSi;
        end else if (cls == 4'b0010 && !opcode.branch.loadStore) begin
            isValid = 1'b1;
            // Untaken branch simply fetches the next word
            if (flags[opcode.branch.flagSel] == opcode.branch.polarity)
                mainState = FTYPE;
            else
                mainState = FETCH;
        end else if (cls == 4'b0011) begin // Stack ops
            case (opcode.raw[8:7])
                2'b00: begin
                    mainState = PUSH1;
                    isValid = !memSource;
                end
                2'b01: begin
                    mainState = POP1;
                    isValid = !badDestI; // POP uses src1 as destination
                end
                default: mainState = HALT; // Call and return dropped
            endcase
        end
    end

endmodule

// ==== source/microOpDecoder.sv ====
module microOpDecoder (
    input  cpuCtrlPkg::ctrlState state,
    input  logic [cpuCtrlPkg::stepWidth-1:0] step,
    input  cpuCtrlPkg::instrWord opcode,
    output logic [cpuCtrlPkg::memSelWidth-1:0] memAddr,
    output logic enPC,
    output logic saveOpcode,
    output logic saveMem1,
    output logic enFP,
    output logic [cpuCtrlPkg::aluFuncWidth-1:0] aluFunc,
    output logic [cpuCtrlPkg::aluSelWidth-1:0] aluA,
    output logic [cpuCtrlPkg::aluSelWidth-1:0] aluB,
    output logic enA,
    output logic enB,
    output logic enC,
    output logic we,
    output logic re,
    output logic [cpuCtrlPkg::writeSelWidth-1:0] writeDataSource,
    output logic enF,
    output logic [cpuCtrlPkg::flagSelWidth-1:0] sourceF,
    output logic enSP,
    output logic turnOffIRQ,
    output logic readStack,
    output logic isMul,
    output logic initSPFP
);
    import cpuCtrlPkg::*;

    logic [destWidth-1:0] destSel; // Destination field of the current class
    logic destOn;

    function automatic logic [aluSelWidth-1:0] regSel(input logic [2:0] src);
        return aluSelWidth'(src[1:0]);
    endfunction

    always_comb begin
        memAddr = MEM_FROM_PC;
        enPC = 1'b0;
        saveOpcode = 1'b0;
        saveMem1 = 1'b0;
        enFP = 1'b0;
        aluFunc = ALU_ADD;
        aluA = '0;
        aluB = '0;
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        we = 1'b0;
        re = 1'b0;
        writeDataSource = WRITE_FROM_ALU;
        enF = 1'b0;
        sourceF = FLAG_FROM_ALU;
        enSP = 1'b0;
        turnOffIRQ = 1'b0;
        readStack = 1'b0;
        isMul = 1'b0;
        initSPFP = 1'b0;
        destSel = DEST_0;
        destOn = 1'b0;
        case (state)
            START: begin
                initSPFP = 1'b1;
                enSP = 1'b1;
                enFP = 1'b1;
            end
            FETCH: begin
                re = 1'b1; // Instruction read at PC
                saveOpcode = 1'b1;
                aluA = ALU1_FROM_PC;
                aluB = ALU2_FROM_2; // PC step of one word
                enPC = 1'b1;
            end
            ATYPE: begin
                aluA = regSel(opcode.aType.src1);
                aluB = aluSelWidth'(opcode.aType.aluB);
                aluFunc = opcode.aType.func;
                enF = |opcode.raw; // All zeros is NOP
                if (opcode.aType.func == ALU_MUL) begin
                    enA = 1'b1; // High half of product
                    isMul = 1'b1;
                end
                destSel = opcode.aType.dest;
                destOn = 1'b1;
            end
            ITYPE: begin
                if (opcode.iType.src1 == DEST_0)
                    aluA = ALU1_FROM_SP;
                else if (opcode.iType.src1[2])
                    aluA = ALU1_FROM_MEM;
                else
                    aluA = regSel(opcode.iType.src1);
                aluFunc = {opcode.iType.signExt, opcode.iType.signExt, opcode.iType.cls[1:0]};
                aluB = ALU2_FROM_OP;
                enF = 1'b1;
                enSP = (opcode.iType.src1 == DEST_0);
                destSel = opcode.iType.src1;
                destOn = 1'b1;
            end
            SITYPE: begin
                aluA = regSel(opcode.siType.src1);
                aluFunc = {2'b10, opcode.siType.shiftFunc}; // Shifter functions
                aluB = ALU2_FROM_OP;
                enF = 1'b1;
                destSel = opcode.siType.dest;
                destOn = 1'b1;
            end
            JMP: begin
                aluA = ALU1_FROM_PC;
                aluB = ALU2_FROM_ADDR; // Long offset
                enPC = 1'b1;
            end
            FTYPE: begin
                aluA = ALU1_FROM_PC;
                aluB = ALU2_FROM_FADDR; // Short offset
                enPC = 1'b1;
            end
            PUSH1: begin
                aluA = regSel(opcode.aType.src1);
                aluB = ALU2_FROM_0;
                we = 1'b1;
                readStack = 1'b1;
                memAddr = MEM_FROM_SP;
            end
            PUSH2: begin
                aluA = ALU1_FROM_SP;
                aluB = ALU2_FROM_2;
                aluFunc = ALU_SUB;
                enSP = 1'b1; // Stack grows down
            end
            POP1: begin
                aluA = ALU1_FROM_SP;
                aluB = ALU2_FROM_2;
                enSP = 1'b1;
                memAddr = MEM_FROM_ALU; // Read at the new SP
                readStack = 1'b1;
                saveMem1 = 1'b1;
                re = 1'b1;
            end
            POP2: begin
                aluA = ALU1_FROM_MEM;
                aluB = ALU2_FROM_0;
                if (opcode.aType.src1 == DEST_0) begin
                    enF = 1'b1; // Pop into flag register
                    sourceF = FLAG_FROM_ALU_OUT;
                end
                destSel = opcode.aType.src1;
                destOn = 1'b1;
            end
            INTSAVE: begin
                aluA = ALU1_FROM_SP;
                aluB = ALU2_FROM_2;
                aluFunc = ALU_SUB;
                enSP = 1'b1;
                memAddr = MEM_FROM_SP;
                readStack = 1'b1;
                we = 1'b1;
                case (step)
                    3'd0: writeDataSource = WRITE_FROM_PC2;
                    3'd1: begin
                        writeDataSource = WRITE_FROM_PC1;
                        turnOffIRQ = 1'b1;
                    end
                    3'd2: begin
                        writeDataSource = WRITE_FROM_FP;
                        enFP = 1'b1;
                    end
                    3'd3: writeDataSource = WRITE_FROM_F;
                    3'd4: writeDataSource = WRITE_FROM_INTDATA;
                    3'd5: writeDataSource = WRITE_FROM_C;
                    3'd6: writeDataSource = WRITE_FROM_B;
                    default: begin
                        writeDataSource = WRITE_FROM_A;
                        enFP = 1'b1; // Frame pointer moves to the new frame
                    end
                endcase
            end
            INTVECTOR: begin
                aluA = ALU1_FROM_INTADDR;
                aluB = ALU2_FROM_0;
                enPC = 1'b1;
            end
            default: begin
            end
        endcase
        if (destOn) begin
            case (destSel)
                DEST_A: enA = 1'b1;
                DEST_B: enB = 1'b1;
                DEST_C: enC = 1'b1;
                DEST_ADR: begin
                    we = 1'b1;
                    writeDataSource = WRITE_FROM_ALU;
                    memAddr = MEM_FROM_A;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== source/stackStepCounter.sv ====
module stackStepCounter (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic stepRun,
    output logic [cpuCtrlPkg::stepWidth-1:0] step,
    output logic stepLast
);
    import cpuCtrlPkg::*;

    always_ff @(posedge clk) begin
        if (rst || !stepRun)
            step <= '0; // Ready for the first save word
        else if (!stall)
            step <= step + 1'b1;
    end

    assign stepLast = (step == stepWidth'(intSaveSteps - 1));

    // Sequencer must drop stepRun as the count reaches the end
    noWrap: assert property (@(posedge clk) disable iff (rst)
        (stepRun && stepLast && !stall) |=> !stepRun)
        else $error("Save step counter wrapped inside INTSAVE");

endmodule

// ==== sources.f ====
source/cpuCtrlPkg.sv
source/instrDecoder.sv
source/ctrlSequencer.sv
source/stackStepCounter.sv
source/microOpDecoder.sv
source/cpuController.sv
tests/ctrlChecks.sv
tests/cpuControllerTb.sv

// ==== tests/cpuControllerTb.sv ====
module cpuControllerTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuCtrlPkg::*;

    localparam int numInstr = 400; // Words drawn over the run

    logic clk, rst, stall, irq, failed;
    instrWord opcode;
    logic [flagWidth-1:0] flags;
    ctrlState state;
    logic [memSelWidth-1:0] memAddr;
    logic [aluFuncWidth-1:0] aluFunc;
    logic [aluSelWidth-1:0] aluA, aluB;
    logic [writeSelWidth-1:0] writeDataSource;
    logic [flagSelWidth-1:0] sourceF;
    logic enPC, saveOpcode, saveMem1, enFP, enA, enB, enC, we, re;
    logic enF, enSP, turnOffIRQ, readStack, isMul, initSPFP;
    logic [31:0] lfsr;
    int drawn;

    cpuController dut0 (.*);
    ctrlChecks checks0 (.*);

    function automatic logic [31:0] lfsrNext(input logic [31:0] v);
        return v[0] ? ((v >> 1) ^ 32'h80200003) : (v >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            bits = {bits[14:0], lfsr[0]};
        end
    endtask

    // Class first, then the field bits
    task automatic drawWord();
        logic [15:0] cls;
        logic [15:0] f;
        takeBits(3, cls);
        takeBits(14, f);
        case (cls[2:0])
            3'd0: opcode.raw = {5'b00000, f[10:0]}; // A type, register source
            3'd1: opcode.raw = {2'b01, f[13:0]};
            3'd2: opcode.raw = {5'b00010, f[10:0]}; // SI type
            3'd3: opcode.raw = {2'b11, f[13:0]};
            3'd4: opcode.raw = {4'b0010, f[11:9], 1'b0, f[7:0]}; // F type
            3'd5: opcode.raw = {4'b0011, f[11:9], 2'b00, f[6:0]}; // Push
            3'd6: opcode.raw = {4'b0011, f[11:9], 2'b01, f[6:0]}; // Pop
            default: opcode.raw = {2'b10, f[13:0]}; // Unknown class
        endcase
        takeBits(4, f);
        flags = f[3:0];
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(numInstr * 20 * 20);
        $display("Watchdog expired before all instructions were issued");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    always @(posedge failed) begin
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    end

    initial begin
        logic [15:0] r;
        lfsr = 32'he20a5f22;
        rst = 1'b1;
        stall = 1'b0;
        irq = 1'b0;
        opcode = '0;
        flags = '0;
        drawn = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        while (drawn < numInstr) begin
            @(negedge clk);
            if (state == HALT) begin
                stall = 1'b0;
                repeat (3) @(negedge clk); // HALT stays visible for a few cycles
                rst = 1'b1; // Only reset leaves HALT
                @(negedge clk);
                rst = 1'b0;
            end else begin
                if (!stall && state == FETCH) begin
                    drawWord();
                    drawn++;
                end
                takeBits(3, r);
                stall = (r[2:0] == 3'd0);
                takeBits(5, r);
                irq = irq ? (r[2:0] != 3'd0) : (r[4:0] == 5'd0); // Windows of a few cycles
            end
        end
        repeat (4) @(negedge clk);
        if (failed) begin
            $display("Test failed");
            $fatal(1, "Checker reported an error");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== tests/ctrlChecks.sv ====
module ctrlChecks (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic irq,
    input  cpuCtrlPkg::instrWord opcode,
    input  logic [cpuCtrlPkg::flagWidth-1:0] flags,
    input  cpuCtrlPkg::ctrlState state,
    input  logic [cpuCtrlPkg::memSelWidth-1:0] memAddr,
    input  logic [cpuCtrlPkg::aluFuncWidth-1:0] aluFunc,
    input  logic [cpuCtrlPkg::aluSelWidth-1:0] aluA,
    input  logic [cpuCtrlPkg::aluSelWidth-1:0] aluB,
    input  logic [cpuCtrlPkg::writeSelWidth-1:0] writeDataSource,
    input  logic [cpuCtrlPkg::flagSelWidth-1:0] sourceF,
    input  logic enPC, saveOpcode, saveMem1, enFP, enA, enB, enC, we, re,
    input  logic enF, enSP, turnOffIRQ, readStack, isMul, initSPFP,
    output logic failed
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpuCtrlPkg::*;

    ctrlState prevState;
    instrWord prevOpcode;
    logic [flagWidth-1:0] prevFlags;
    logic prevRst, prevStall, prevIrq;
    logic [stepWidth-1:0] saveIdx, prevIdx; // Save word index inside INTSAVE
    ctrlState expNext;
    logic [11:0] strobeVec;
    logic [12:0] aVec, aExp;
    logic [11:0] saveVec, saveExp;
    logic [35:0] outs, prevOuts;

    // Main state after FETCH with invalid words going to HALT
    function automatic ctrlState fetchTarget(input instrWord op,
            input logic [flagWidth-1:0] fl);
        ctrlState tgt;
        logic regSrc; // Source field names a register
        logic destOk; // Source field used as destination is in range
        regSrc = !op.aType.src1[2];
        destOk = op.aType.src1 < 3'd5;
        tgt = HALT;
        casez (op.raw[15:12])
            4'b0000: begin
                if (regSrc && op.aType.dest < 3'd5)
                    tgt = ATYPE;
            end
            4'b01??: begin
                if (destOk)
                    tgt = ITYPE;
            end
            4'b11??: tgt = JMP;
            4'b0001: begin
                if (regSrc && op.siType.dest < 3'd5)
                    tgt = SITYPE;
            end
            4'b0010: begin
                if (!op.branch.loadStore)
                    tgt = (fl[op.branch.flagSel] == op.branch.polarity) ? FTYPE : FETCH;
            end
            4'b0011: begin
                if (op.raw[8:7] == 2'b00 && regSrc)
                    tgt = PUSH1;
                else if (op.raw[8:7] == 2'b01 && destOk)
                    tgt = POP1;
            end
            default: tgt = HALT; // Unused classes stop the CPU
        endcase
        return tgt;
    endfunction

    function automatic ctrlState modelNext(input ctrlState cur, input instrWord op,
            input logic [flagWidth-1:0] fl, input logic irqIn, input logic [stepWidth-1:0] idx);
        ctrlState nxt;
        case (cur)
            FETCH: nxt = fetchTarget(op, fl);
            PUSH1: nxt = PUSH2;
            POP1: nxt = POP2;
            INTSAVE: nxt = (idx == 3'd7) ? INTVECTOR : INTSAVE;
            HALT: nxt = HALT;
            default: nxt = FETCH;
        endcase
        if (nxt == FETCH && irqIn)
            nxt = INTSAVE; // Interrupt replaces the fetch
        return nxt;
    endfunction

    function automatic logic [3:0] destEnables(input instrWord op);
        logic [3:0] en; // enA, enB, enC, we
        case (op.aType.dest)
            DEST_A: en = 4'b1000;
            DEST_B: en = 4'b0100;
            DEST_C: en = 4'b0010;
            DEST_ADR: en = 4'b0001;
            default: en = 4'b0000;
        endcase
        if (op.aType.func == ALU_MUL)
            en[3] = 1'b1;
        return en;
    endfunction

    function automatic logic [writeSelWidth-1:0] saveSource(input logic [stepWidth-1:0] idx);
        logic [writeSelWidth-1:0] order [8];
        order = '{WRITE_FROM_PC2, WRITE_FROM_PC1, WRITE_FROM_FP, WRITE_FROM_F,
                  WRITE_FROM_INTDATA, WRITE_FROM_C, WRITE_FROM_B, WRITE_FROM_A};
        return order[idx];
    endfunction

    task automatic reportError(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        $display("ERR %s expected %0h actual %0h", name, expected, actual);
        failed = 1'b1;
    endtask

    initial begin
        failed = 1'b0;
        prevRst = 1'b1;
    end

    always @(posedge clk) begin
        prevState <= state;
        prevOpcode <= opcode;
        prevFlags <= flags;
        prevRst <= rst;
        prevStall <= stall;
        prevIrq <= irq;
        prevIdx <= saveIdx;
        prevOuts <= outs;
        if (rst || state != INTSAVE)
            saveIdx <= '0;
        else if (!stall)
            saveIdx <= saveIdx + 1'b1;
    end

    assign expNext = prevStall ? prevState
                               : modelNext(prevState, prevOpcode, prevFlags, prevIrq, prevIdx);
    assign strobeVec = {initSPFP, enSP, enFP, we, enPC, enA, enB, enC, enF,
                        saveOpcode, saveMem1, turnOffIRQ};
    assign aVec = {aluFunc, enA, enB, enC, we, memAddr, enF, isMul};
    assign aExp = {opcode.aType.func, destEnables(opcode),
                   (opcode.aType.dest == DEST_ADR) ? MEM_FROM_A : MEM_FROM_PC,
                   |opcode.raw, opcode.aType.func == ALU_MUL};
    assign saveVec = {writeDataSource, turnOffIRQ, enFP, we, enSP, aluFunc};
    assign saveExp = {saveSource(saveIdx), saveIdx == 3'd1, saveIdx == 3'd2 || saveIdx == 3'd7,
                      2'b11, ALU_SUB};
    assign outs = {memAddr, enPC, saveOpcode, saveMem1, enFP, aluFunc, aluA, aluB,
                   enA, enB, enC, we, re, writeDataSource, enF, sourceF,
                   enSP, turnOffIRQ, readStack, isMul, initSPFP};

    startOut: assert property (@(posedge clk) disable iff (rst)
        state == START |-> strobeVec == 12'he00)
        else reportError("startOut", 32'he00, int'($sampled(strobeVec)));
    haltOut: assert property (@(posedge clk) disable iff (rst)
        state == HALT |-> strobeVec == 12'h000)
        else reportError("haltOut", 0, int'($sampled(strobeVec)));
    fetchOut: assert property (@(posedge clk) disable iff (rst)
        state == FETCH |-> {re, saveOpcode, enPC, memAddr, aluB}
            == {3'b111, MEM_FROM_PC, ALU2_FROM_2})
        else reportError("fetchOut", int'({3'b111, MEM_FROM_PC, ALU2_FROM_2}),
            int'($sampled({re, saveOpcode, enPC, memAddr, aluB})));
    nextState: assert property (@(posedge clk) disable iff (rst)
        !prevRst |-> state == expNext)
        else reportError("nextState", int'($sampled(expNext)), int'($sampled(state)));
    aTypeOut: assert property (@(posedge clk) disable iff (rst)
        state == ATYPE |-> aVec == aExp)
        else reportError("aTypeOut", int'($sampled(aExp)), int'($sampled(aVec)));
    iTypeOut: assert property (@(posedge clk) disable iff (rst)
        state == ITYPE |-> {aluB, enSP} == {ALU2_FROM_OP, opcode.iType.src1 == DEST_0})
        else reportError("iTypeOut", int'({ALU2_FROM_OP, $sampled(opcode.iType.src1) == DEST_0}),
            int'($sampled({aluB, enSP})));
    jmpOut: assert property (@(posedge clk) disable iff (rst)
        state == JMP |-> {aluB, enPC} == {ALU2_FROM_ADDR, 1'b1})
        else reportError("jmpOut", int'({ALU2_FROM_ADDR, 1'b1}), int'($sampled({aluB, enPC})));
    pcLoad: assert property (@(posedge clk) disable iff (rst)
        state inside {FTYPE, INTVECTOR} |-> enPC)
        else reportError("pcLoad", 1, int'($sampled(enPC)));
    push1Out: assert property (@(posedge clk) disable iff (rst)
        state == PUSH1 |-> {we, readStack, memAddr} == {2'b11, MEM_FROM_SP})
        else reportError("push1Out", int'({2'b11, MEM_FROM_SP}),
            int'($sampled({we, readStack, memAddr})));
    push2Out: assert property (@(posedge clk) disable iff (rst)
        state == PUSH2 |-> {enSP, aluFunc} == {1'b1, ALU_SUB})
        else reportError("push2Out", int'({1'b1, ALU_SUB}), int'($sampled({enSP, aluFunc})));
    pop1Out: assert property (@(posedge clk) disable iff (rst)
        state == POP1 |-> {re, saveMem1, enSP, aluFunc} == {3'b111, ALU_ADD})
        else reportError("pop1Out", int'({3'b111, ALU_ADD}),
            int'($sampled({re, saveMem1, enSP, aluFunc})));
    pop2Flags: assert property (@(posedge clk) disable iff (rst)
        (state == POP2 && opcode.aType.src1 == DEST_0) |->
            {enF, sourceF} == {1'b1, FLAG_FROM_ALU_OUT})
        else reportError("pop2Flags", int'({1'b1, FLAG_FROM_ALU_OUT}),
            int'($sampled({enF, sourceF})));
    saveOut: assert property (@(posedge clk) disable iff (rst)
        state == INTSAVE |-> saveVec == saveExp)
        else reportError("saveOut", int'($sampled(saveExp)), int'($sampled(saveVec)));
    stallHold: assert property (@(posedge clk) disable iff (rst)
        (prevStall && !prevRst) |-> outs == prevOuts)
        else reportError("stallHold", $sampled(prevOuts), $sampled(outs));

endmodule
